// File: flist.f
design/i2c_pkg.sv
design/apb_i2c_regs.sv
design/i2c_control.sv
design/i2c_bit_shift.sv
design/i2c_master_top.sv
test/i2c_slave_model.sv
test/tb_i2c_master.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_i2c_master -f flist.f

out=$(./obj_dir/Vtb_i2c_master)
echo "$out"
echo "$out" | grep -q "Verification passed"

// File: test/tb_i2c_master.sv
`timescale 1ns/1ps

module tb_i2c_master;

	localparam int CLK_DIV  = 4;
	localparam int NUM_ROWS = 10;
	localparam int MAX_DLY  = 50;
	// Two extra transfers come from the busy test
	localparam int LIMIT = (NUM_ROWS + 2) * (24 * 4 * CLK_DIV + MAX_DLY + 200);

	// Stimulus table, one column per field
	localparam bit       ROW_RD   [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1,
		1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
	localparam bit [6:0] ROW_ADDR [NUM_ROWS] = '{7'h3C, 7'h3C, 7'h22, 7'h3C, 7'h22,
		7'h3C, 7'h3C, 7'h3C, 7'h3C, 7'h3C};
	localparam bit       ROW_RAND [NUM_ROWS] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0,
		1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
	localparam bit [7:0] ROW_DATA [NUM_ROWS] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
		8'h00, 8'h00, 8'h00, 8'hA5, 8'h00};
	localparam int       ROW_DLY  [NUM_ROWS] = '{0, 0, 0, 0, 0, 50, 50, 0, 50, 0};
	localparam bit       ROW_ACK  [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1,
		1'b0, 1'b0, 1'b0, 1'b0, 1'b0};

	logic        Clk;
	logic        Rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        i2c_scl;
	logic        sda_oe;
	logic        slave_oe;
	logic        sda;

	int          cycles = 0;
	int          errors = 0;
	int          passed = 0;
	int          failed = 0;
	logic [31:0] lfsr = 32'h5d6f_5900;
	logic [7:0]  last_written = 8'h00; // Byte the slave model should hold

	assign sda = !(sda_oe || slave_oe); // Wired-AND with pull-up

	i2c_master_top #(
		.CLK_DIV (CLK_DIV)
	) uut (
		.Clk     (Clk),
		.Rst_n   (Rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.i2c_scl (i2c_scl),
		.sda_oe  (sda_oe),
		.sda_i   (sda)
	);

	i2c_slave_model #(
		.DEV_ADDR (7'h3C)
	) slave (
		.scl    (i2c_scl),
		.sda    (sda),
		.sda_oe (slave_oe)
	);

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	always @(posedge Clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic next_byte(output logic [7:0] b);
		b = 8'h00;
		for (int k = 0; k < 8; k++) begin
			b    = {b[6:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// Setup and access cycle, sampled at the falling edge of the access cycle
	task automatic bus_access(input logic wr, input logic [7:0] addr,
		input logic [31:0] data, output logic [31:0] rdata, output logic err);
		@(posedge Clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		@(posedge Clk);
		#1;
		penable = 1'b1;
		@(negedge Clk);
		rdata = prdata;
		err   = pslverr;
		check_value("pready", 32'd1, 32'(pready)); // No wait states
		@(posedge Clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		bus_access(1'b1, addr, data, unused, err);
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
		bus_access(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("Mismatch %s exp %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic wait_done(output logic [31:0] status);
		logic err;
		status = 32'd0;
		while (!status[1])
			read_reg(i2c_pkg::REG_STATUS, status, err);
	endtask

	task automatic close_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			passed++;
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: FAILED", name);
		end
	endtask

	task automatic start_transfer(input logic rd);
		logic [31:0] status;
		logic        err;
		write_reg(i2c_pkg::REG_CTRL, rd ? 32'd2 : 32'd1, err);
		check_value("pslverr", 32'd0, 32'(err));
		read_reg(i2c_pkg::REG_STATUS, status, err);
		check_value("busy", 32'd1, 32'(status[0]));
	endtask

	task automatic run_row(input int i);
		logic [7:0]  data;
		logic [31:0] status;
		logic [31:0] rdata;
		logic        err;
		int          errs_before;
		errs_before = errors;
		data = ROW_DATA[i];
		if (ROW_RAND[i])
			next_byte(data);
		write_reg(i2c_pkg::REG_DEV, 32'(ROW_ADDR[i]), err);
		write_reg(i2c_pkg::REG_WDATA, 32'(data), err);
		write_reg(i2c_pkg::REG_DLY, 32'(ROW_DLY[i]), err);
		start_transfer(ROW_RD[i]);
		wait_done(status);
		check_value("busy", 32'd0, 32'(status[0]));
		check_value("ack_err", 32'(ROW_ACK[i]), 32'(status[2]));
		check_value("i2c_scl", 32'd1, 32'(i2c_scl)); // Bus idle after STOP
		check_value("sda_oe", 32'd0, 32'(sda_oe));
		if (ROW_RD[i]) begin
			read_reg(i2c_pkg::REG_RDATA, rdata, err);
			// An absent target leaves the line pulled high
			check_value("rdata", ROW_ACK[i] ? 32'h0000_00FF : 32'(last_written), rdata);
		end else if (!ROW_ACK[i]) begin
			last_written = data;
		end
		close_test($sformatf("Row %0d %s addr %h data %h dly %0d", i,
			ROW_RD[i] ? "read " : "write", ROW_ADDR[i], data, ROW_DLY[i]), errs_before);
	endtask

	task automatic busy_refusal();
		logic [7:0]  data;
		logic [31:0] status;
		logic [31:0] rdata;
		logic        err;
		int          errs_before;
		errs_before = errors;
		next_byte(data);
		write_reg(i2c_pkg::REG_DEV, 32'h0000_003C, err);
		write_reg(i2c_pkg::REG_WDATA, 32'(data), err);
		write_reg(i2c_pkg::REG_DLY, 32'd0, err);
		start_transfer(1'b0);
		write_reg(i2c_pkg::REG_WDATA, 32'(~data), err); // Must not reach the bus
		write_reg(i2c_pkg::REG_CTRL, 32'd2, err);
		check_value("pslverr", 32'd1, 32'(err));
		wait_done(status);
		check_value("ack_err", 32'd0, 32'(status[2]));
		last_written = data;
		start_transfer(1'b1);
		wait_done(status);
		read_reg(i2c_pkg::REG_RDATA, rdata, err);
		check_value("rdata", 32'(last_written), rdata);
		write_reg(8'h1C, 32'h0000_0001, err);
		check_value("pslverr", 32'd1, 32'(err));
		read_reg(8'h1C, rdata, err);
		check_value("pslverr", 32'd1, 32'(err));
		close_test("Busy start refusal and unmapped offset", errs_before);
	endtask

	task automatic reg_readback();
		logic [31:0] rdata;
		logic        err;
		int          errs_before;
		errs_before = errors;
		write_reg(i2c_pkg::REG_DEV, 32'h0000_00C5, err);
		read_reg(i2c_pkg::REG_DEV, rdata, err);
		check_value("dev", 32'h0000_00C5 & 32'h0000_007F, rdata); // 7-bit field
		write_reg(i2c_pkg::REG_WDATA, 32'h0000_005A, err);
		read_reg(i2c_pkg::REG_WDATA, rdata, err);
		check_value("wdata", 32'h0000_005A, rdata);
		write_reg(i2c_pkg::REG_DLY, 32'h0001_2345, err);
		read_reg(i2c_pkg::REG_DLY, rdata, err);
		check_value("dly", 32'h0001_2345, rdata);
		close_test("Register read back", errs_before);
	endtask

	initial begin
		Rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = 8'h00;
		pwdata  = 32'd0;
		repeat (3) @(posedge Clk);
		#1;
		Rst_n = 1'b1;
		for (int i = 0; i < NUM_ROWS; i++)
			run_row(i);
		busy_refusal();
		reg_readback();
		$display("Tests passed %0d, failed %0d, check errors %0d", passed, failed, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: test/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
	parameter logic [6:0] DEV_ADDR = 7'h3C
) (
	input  logic scl,
	input  logic sda,
	output logic sda_oe
);

	logic [7:0] mem; // One byte of storage
	logic [7:0] rx;

	// Eight bits MSB first, returns after the falling SCL of the last bit
	task automatic get_byte(output logic [7:0] b);
		b = 8'h00;
		for (int i = 0; i < 8; i++) begin
			@(posedge scl);
			b = {b[6:0], sda};
		end
		@(negedge scl);
	endtask

	task automatic send_byte(input logic [7:0] b);
		sda_oe = !b[7];
		for (int i = 6; i >= 0; i--) begin
			@(negedge scl);
			sda_oe = !b[i];
		end
		@(negedge scl);
		sda_oe = 1'b0; // Release for the master's NACK
	endtask

	initial begin
		mem    = 8'h00;
		rx     = 8'h00;
		sda_oe = 1'b0;
		forever begin
			@(negedge sda);
			if (scl) begin // START condition
				get_byte(rx);
				if (rx[7:1] == DEV_ADDR) begin
					sda_oe = 1'b1; // Address ack
					@(negedge scl);
					if (rx[0]) begin
						send_byte(mem);
					end else begin
						sda_oe = 1'b0;
						get_byte(rx);
						sda_oe = 1'b1; // Data ack
						@(negedge scl);
						sda_oe = 1'b0;
						mem    = rx;
					end
				end
			end
		end
	end

endmodule

// File: design/i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top #(
	parameter int CLK_DIV = 4
) (
	input  logic        Clk,
	input  logic        Rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        i2c_scl,
	output logic        sda_oe,
	input  logic        sda_i
);

	logic        wr_req;
	logic        rd_req;
	logic [7:0]  wrdata;
	logic [7:0]  device_id;
	logic [31:0] dly_cnt_max;
	logic        rw_done;
	logic        ack;
	logic [7:0]  rddata;
	logic [5:0]  cmd;
	logic        go;
	logic [7:0]  tx_data;
	logic        trans_done;
	logic        ack_o;
	logic [7:0]  rx_data;

	apb_i2c_regs u_regs (
		.Clk         (Clk),
		.Rst_n       (Rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.wr_req      (wr_req),
		.rd_req      (rd_req),
		.wrdata      (wrdata),
		.device_id   (device_id),
		.dly_cnt_max (dly_cnt_max),
		.rw_done     (rw_done),
		.ack         (ack),
		.rddata      (rddata)
	);

	i2c_control u_control (
		.Clk         (Clk),
		.Rst_n       (Rst_n),
		.wr_req      (wr_req),
		.rd_req      (rd_req),
		.wrdata      (wrdata),
		.device_id   (device_id),
		.dly_cnt_max (dly_cnt_max),
		.rw_done     (rw_done),
		.ack         (ack),
		.rddata      (rddata),
		.cmd         (cmd),
		.go          (go),
		.tx_data     (tx_data),
		.trans_done  (trans_done),
		.ack_o       (ack_o),
		.rx_data     (rx_data)
	);

	i2c_bit_shift #(
		.CLK_DIV (CLK_DIV)
	) u_bit_shift (
		.Clk        (Clk),
		.Rst_n      (Rst_n),
		.cmd        (cmd),
		.go         (go),
		.tx_data    (tx_data),
		.trans_done (trans_done),
		.ack_o      (ack_o),
		.rx_data    (rx_data),
		.i2c_scl    (i2c_scl),
		.sda_oe     (sda_oe),
		.sda_i      (sda_i)
	);

endmodule

// File: design/i2c_bit_shift.sv
`timescale 1ns/1ps

module i2c_bit_shift #(
	parameter int CLK_DIV = 4
) (
	input  logic       Clk,
	input  logic       Rst_n,
	input  logic [5:0] cmd,
	input  logic       go,
	input  logic [7:0] tx_data,
	output logic       trans_done,
	output logic       ack_o,
	output logic [7:0] rx_data,
	output logic       i2c_scl,
	output logic       sda_oe,
	input  logic       sda_i
);

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	i2c_pkg::shift_state_e state;
	logic [DIV_W-1:0] div_cnt;
	logic [1:0]       quarter; // Position inside the SCL period
	logic [2:0]       bit_cnt;
	logic             tick;
	logic             q_start;
	logic             q_last;

	assign tick    = (div_cnt == DIV_W'(CLK_DIV - 1));
	assign q_start = (div_cnt == '0);
	assign q_last  = tick && (quarter == 2'd3);

	// Phase after START
	function automatic i2c_pkg::shift_state_e body_state(input logic [5:0] c);
		if (c[i2c_pkg::CMD_WR])
			return i2c_pkg::WR_BITS;
		else if (c[i2c_pkg::CMD_RD])
			return i2c_pkg::RD_BITS;
		else
			return i2c_pkg::GEN_STO;
	endfunction

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			div_cnt <= '0;
			quarter <= 2'd0;
		end else if (state == i2c_pkg::SHIFT_IDLE) begin
			div_cnt <= '0;
			quarter <= 2'd0;
		end else if (tick) begin
			div_cnt <= '0;
			quarter <= quarter + 2'd1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state      <= i2c_pkg::SHIFT_IDLE;
			bit_cnt    <= 3'd0;
			trans_done <= 1'b0;
			ack_o      <= 1'b0;
			i2c_scl    <= 1'b1; // Bus idle high
			sda_oe     <= 1'b0;
		end else begin
			trans_done <= 1'b0;
			case (state)
				i2c_pkg::SHIFT_IDLE: begin
					bit_cnt <= 3'd0;
					if (go)
						state <= cmd[i2c_pkg::CMD_STA] ? i2c_pkg::GEN_STA : body_state(cmd);
				end
				i2c_pkg::GEN_STA: begin
					if (q_start) begin
						case (quarter)
							2'd0: begin
								i2c_scl <= 1'b1;
								sda_oe  <= 1'b0;
							end
							2'd2: sda_oe <= 1'b1; // SDA falls with SCL high
							2'd3: i2c_scl <= 1'b0;
							default: ;
						endcase
					end
					if (q_last)
						state <= body_state(cmd);
				end
				i2c_pkg::WR_BITS: begin
					if (q_start) begin
						case (quarter)
							2'd0: sda_oe <= !tx_data[3'd7 - bit_cnt]; // MSB first
							2'd1: i2c_scl <= 1'b1;
							2'd3: i2c_scl <= 1'b0;
							default: ;
						endcase
					end
					if (q_last) begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= i2c_pkg::CHECK_ACK;
					end
				end
				i2c_pkg::RD_BITS: begin
					if (q_start) begin
						case (quarter)
							2'd0: sda_oe <= 1'b0; // Target drives the line
							2'd1: i2c_scl <= 1'b1;
							2'd3: i2c_scl <= 1'b0;
							default: ;
						endcase
					end
					if (q_last) begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= i2c_pkg::GEN_ACK;
					end
				end
				i2c_pkg::CHECK_ACK, i2c_pkg::GEN_ACK: begin
					if (q_start) begin
						case (quarter)
							2'd0: begin
								if (state == i2c_pkg::GEN_ACK)
									sda_oe <= cmd[i2c_pkg::CMD_ACK]; // NACK leaves SDA released
								else
									sda_oe <= 1'b0;
							end
							2'd1: i2c_scl <= 1'b1;
							2'd2: begin
								if (state == i2c_pkg::CHECK_ACK)
									ack_o <= sda_i; // High means no ack
							end
							2'd3: i2c_scl <= 1'b0;
							default: ;
						endcase
					end
					if (q_last) begin
						if (cmd[i2c_pkg::CMD_STO]) begin
							state <= i2c_pkg::GEN_STO;
						end else begin
							state      <= i2c_pkg::SHIFT_IDLE;
							trans_done <= 1'b1;
						end
					end
				end
				i2c_pkg::GEN_STO: begin
					if (q_start) begin
						case (quarter)
							2'd0: sda_oe <= 1'b1;
							2'd1: i2c_scl <= 1'b1;
							2'd2: sda_oe <= 1'b0; // SDA rises with SCL high
							default: ;
						endcase
					end
					if (q_last) begin
						state      <= i2c_pkg::SHIFT_IDLE;
						trans_done <= 1'b1;
					end
				end
				default: state <= i2c_pkg::SHIFT_IDLE;
			endcase
		end
	end

	// Sample one quarter after the SCL rise
	always_ff @(posedge Clk) begin
		if (state == i2c_pkg::RD_BITS && q_start && quarter == 2'd2)
			rx_data <= {rx_data[6:0], sda_i};
	end

	assert property (@(posedge Clk) disable iff (!Rst_n)
		(i2c_scl && $past(i2c_scl) && state != i2c_pkg::GEN_STA && state != i2c_pkg::GEN_STO)
		|-> $stable(sda_oe))
		else $error("SDA changed while SCL high");

endmodule

// File: design/i2c_control.sv
`timescale 1ns/1ps

module i2c_control (
	input  logic        Clk,
	input  logic        Rst_n,
	input  logic        wr_req,
	input  logic        rd_req,
	input  logic [7:0]  wrdata,
	input  logic [7:0]  device_id,
	input  logic [31:0] dly_cnt_max,
	output logic        rw_done,
	output logic        ack,
	output logic [7:0]  rddata,
	output logic [5:0]  cmd,
	output logic        go,
	output logic [7:0]  tx_data,
	input  logic        trans_done,
	input  logic        ack_o,
	input  logic [7:0]  rx_data
);

	localparam logic [5:0] M_WR   = 6'b1 << i2c_pkg::CMD_WR;
	localparam logic [5:0] M_STA  = 6'b1 << i2c_pkg::CMD_STA;
	localparam logic [5:0] M_RD   = 6'b1 << i2c_pkg::CMD_RD;
	localparam logic [5:0] M_STO  = 6'b1 << i2c_pkg::CMD_STO;
	localparam logic [5:0] M_NACK = 6'b1 << i2c_pkg::CMD_NACK;

	i2c_pkg::ctrl_state_e state;
	logic        byte_idx; // 0 address byte, 1 data byte
	logic [31:0] dly_cnt;
	logic [7:0]  wrdata_q;

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state    <= i2c_pkg::CTRL_IDLE;
			byte_idx <= 1'b0;
			dly_cnt  <= '0;
			cmd      <= '0;
			go       <= 1'b0;
			rw_done  <= 1'b0;
			ack      <= 1'b0;
		end else begin
			go      <= 1'b0; // Single cycle pulses
			rw_done <= 1'b0;
			case (state)
				i2c_pkg::CTRL_IDLE: begin
					byte_idx <= 1'b0;
					dly_cnt  <= '0;
					if (wr_req) begin
						ack   <= 1'b0;
						state <= i2c_pkg::WR_OP;
					end else if (rd_req) begin
						ack   <= 1'b0;
						state <= i2c_pkg::RD_OP;
					end
				end
				i2c_pkg::WR_OP: begin
					go    <= 1'b1;
					cmd   <= byte_idx ? (M_WR | M_STO) : (M_WR | M_STA);
					state <= i2c_pkg::WAIT_WR_DONE;
				end
				i2c_pkg::WAIT_WR_DONE: begin
					if (trans_done) begin
						ack <= ack | ack_o; // Address and data acks both count
						if (byte_idx) begin
							state <= i2c_pkg::WAIT_DLY;
						end else begin
							byte_idx <= 1'b1;
							state    <= i2c_pkg::WR_OP;
						end
					end
				end
				i2c_pkg::RD_OP: begin
					go    <= 1'b1;
					cmd   <= byte_idx ? (M_RD | M_NACK | M_STO) : (M_WR | M_STA);
					state <= i2c_pkg::WAIT_RD_DONE;
				end
				i2c_pkg::WAIT_RD_DONE: begin
					if (trans_done) begin
						if (!byte_idx) begin
							ack      <= ack | ack_o; // Address phase only
							byte_idx <= 1'b1;
							state    <= i2c_pkg::RD_OP;
						end else begin
							state <= i2c_pkg::WAIT_DLY;
						end
					end
				end
				i2c_pkg::WAIT_DLY: begin
					if (dly_cnt < dly_cnt_max) begin
						dly_cnt <= dly_cnt + 32'd1;
					end else begin
						dly_cnt <= '0;
						rw_done <= 1'b1;
						state   <= i2c_pkg::CTRL_IDLE;
					end
				end
				default: state <= i2c_pkg::CTRL_IDLE;
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if (state == i2c_pkg::CTRL_IDLE && wr_req)
			wrdata_q <= wrdata; // Held for the data byte
		if (state == i2c_pkg::WR_OP)
			tx_data <= byte_idx ? wrdata_q : device_id;
		if (state == i2c_pkg::RD_OP)
			tx_data <= device_id | 8'h01; // Read bit set
		if (state == i2c_pkg::WAIT_RD_DONE && trans_done && byte_idx)
			rddata <= rx_data;
	end

	assert property (@(posedge Clk) disable iff (!Rst_n) go |=> !go)
		else $error("go held for two cycles");

endmodule

// File: design/apb_i2c_regs.sv
`timescale 1ns/1ps

module apb_i2c_regs (
	input  logic        Clk,
	input  logic        Rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        wr_req,
	output logic        rd_req,
	output logic [7:0]  wrdata,
	output logic [7:0]  device_id,
	output logic [31:0] dly_cnt_max,
	input  logic        rw_done,
	input  logic        ack,
	input  logic [7:0]  rddata
);

	logic [6:0]  dev_addr;
	logic [7:0]  wdata_reg;
	logic [31:0] dly_reg;
	logic [7:0]  rdata_reg;
	logic        busy;
	logic        done;
	logic        ack_err;
	logic        access;
	logic        wr_acc;
	logic        ctrl_wr;
	logic        mapped;

	assign access  = psel && penable; // Access phase only
	assign wr_acc  = access && pwrite;
	assign ctrl_wr = wr_acc && (paddr == i2c_pkg::REG_CTRL);
	assign mapped  = paddr inside {i2c_pkg::REG_CTRL, i2c_pkg::REG_DEV, i2c_pkg::REG_WDATA,
		i2c_pkg::REG_DLY, i2c_pkg::REG_STATUS, i2c_pkg::REG_RDATA};

	assign pready  = 1'b1; // Zero wait states
	assign pslverr = access && (!mapped || (ctrl_wr && busy));

	// Write start has priority over read start
	assign wr_req = ctrl_wr && !busy && pwdata[0];
	assign rd_req = ctrl_wr && !busy && !pwdata[0] && pwdata[1];

	assign wrdata      = wdata_reg;
	assign device_id   = {dev_addr, 1'b0};
	assign dly_cnt_max = dly_reg;

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			dev_addr  <= '0;
			wdata_reg <= '0;
			dly_reg   <= '0;
		end else if (wr_acc) begin
			case (paddr)
				i2c_pkg::REG_DEV:   dev_addr  <= pwdata[6:0];
				i2c_pkg::REG_WDATA: wdata_reg <= pwdata[7:0];
				i2c_pkg::REG_DLY:   dly_reg   <= pwdata;
				default: ; // STATUS and RDATA are read only
			endcase
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			busy    <= 1'b0;
			done    <= 1'b0;
			ack_err <= 1'b0;
		end else if (wr_req || rd_req) begin
			busy    <= 1'b1;
			done    <= 1'b0; // New start clears the sticky flags
			ack_err <= 1'b0;
		end else if (rw_done) begin
			busy    <= 1'b0;
			done    <= 1'b1;
			ack_err <= ack;
		end
	end

	always_ff @(posedge Clk) begin
		if (rw_done)
			rdata_reg <= rddata;
	end

	always_comb begin
		case (paddr)
			i2c_pkg::REG_DEV:    prdata = {25'd0, dev_addr};
			i2c_pkg::REG_WDATA:  prdata = {24'd0, wdata_reg};
			i2c_pkg::REG_DLY:    prdata = dly_reg;
			i2c_pkg::REG_STATUS: prdata = {29'd0, ack_err, done, busy};
			i2c_pkg::REG_RDATA:  prdata = {24'd0, rdata_reg};
			default:             prdata = 32'd0;
		endcase
	end

	assert property (@(posedge Clk) disable iff (!Rst_n) !(wr_req && rd_req))
		else $error("wr_req and rd_req high together");

	// The controller only finishes a transfer that was issued
	assert property (@(posedge Clk) disable iff (!Rst_n) rw_done |-> busy)
		else $error("rw_done without an outstanding request");

endmodule

// File: design/i2c_pkg.sv
package i2c_pkg;

	// Bit positions in the 6-bit command mask
	localparam int CMD_WR   = 0;
	localparam int CMD_STA  = 1;
	localparam int CMD_RD   = 2;
	localparam int CMD_STO  = 3;
	localparam int CMD_ACK  = 4;
	localparam int CMD_NACK = 5;

	typedef enum logic [7:0] {
		CTRL_IDLE    = 8'h01,
		WR_OP        = 8'h02,
		WAIT_WR_DONE = 8'h04,
		RD_OP        = 8'h08,
		WAIT_RD_DONE = 8'h10,
		WAIT_DLY     = 8'h20
	} ctrl_state_e;

	typedef enum logic [7:0] {
		SHIFT_IDLE = 8'h01,
		GEN_STA    = 8'h02,
		WR_BITS    = 8'h04,
		RD_BITS    = 8'h08,
		CHECK_ACK  = 8'h10,
		GEN_ACK    = 8'h20,
		GEN_STO    = 8'h40
	} shift_state_e;

	localparam logic [7:0] REG_CTRL   = 8'h00; // Bit 0 write start, bit 1 read start
	localparam logic [7:0] REG_DEV    = 8'h04; // 7-bit target address
	localparam logic [7:0] REG_WDATA  = 8'h08;
	localparam logic [7:0] REG_DLY    = 8'h0C; // Cycles after STOP before done
	localparam logic [7:0] REG_STATUS = 8'h10; // {ack_err, done, busy}
	localparam logic [7:0] REG_RDATA  = 8'h14;

endpackage
